// File: avatar_layer/avatar_layer.sv
`default_nettype none

module avatar_layer
(
	input wire clk,
	input wire rst,
	pixel_if.layer pix,
	input wire [mapper_pkg::COORD_W-1:0] avatar_x_1,
	input wire [mapper_pkg::COORD_W-1:0] avatar_y_1,
	input wire [1:0] avatar_dir_1,
	input wire [mapper_pkg::COORD_W-1:0] avatar_x_2,
	input wire [mapper_pkg::COORD_W-1:0] avatar_y_2,
	input wire [1:0] avatar_dir_2,
	output logic av_hit,
	output mapper_pkg::pal_idx_t av_slot
);

	logic hit_1;
	logic hit_2;
	mapper_pkg::pal_idx_t slot_1;
	mapper_pkg::pal_idx_t slot_2;

	// Box is anchored at the feet, so it reaches further up.
	function automatic logic in_box
	(
		input logic [mapper_pkg::COORD_W-1:0] px,
		input logic [mapper_pkg::COORD_W-1:0] py,
		input logic [mapper_pkg::COORD_W-1:0] ax,
		input logic [mapper_pkg::COORD_W-1:0] ay
	);
		int dx;
		int dy;
		dx = int'(px) - int'(ax);
		dy = int'(py) - int'(ay);
		return (dx >= -mapper_pkg::AV_HALF_W) && (dx < mapper_pkg::AV_HALF_W)
			&& (dy >= -mapper_pkg::AV_UP) && (dy < mapper_pkg::AV_DOWN);
	endfunction

	// ------------------------------
	// Hit boxes
	// ------------------------------
	assign hit_1 = pix.play && in_box(pix.x, pix.y, avatar_x_1, avatar_y_1);
	assign hit_2 = pix.play && in_box(pix.x, pix.y, avatar_x_2, avatar_y_2);

	assign slot_1 = mapper_pkg::SLOT_P1_BASE + {2'b00, avatar_dir_1};  // Facing picks shade.
	assign slot_2 = mapper_pkg::SLOT_P2_BASE + {2'b00, avatar_dir_2};

	always_ff @(posedge clk)
	begin
		if (rst)
			av_hit <= 1'b0;
		else
			av_hit <= hit_1 || hit_2;
		av_slot <= hit_1 ? slot_1 : slot_2;  // Player 1 on top.
	end

endmodule

`default_nettype wire

// File: build.f
common/mapper_pkg.sv
common/pixel_if.sv
hw/palette_regs.sv
hw/pixel_compose.sv
tile_layer/tile_layer.sv
avatar_layer/avatar_layer.sv
hw/color_mapper.sv
testbench/color_mapper_assertions.sv
testbench/tb_color_mapper.sv

// File: common/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

	// ------------------------------
	// Field geometry
	// ------------------------------
	localparam int CELL_PX = 40;
	localparam int GRID_N = 12;
	localparam int FIELD_W = 480;            // Side panel starts here.
	localparam int MAP_BITS = 144;
	localparam int COIN_LO = 13;
	localparam int COIN_HI = 28;
	localparam int AV_HALF_W = 20;
	localparam int AV_UP = 40;               // Box reaches higher above the anchor.
	localparam int AV_DOWN = 20;
	localparam int COORD_W = 10;
	localparam logic [1:0] STATE_PLAY = 2'b01;

	// ------------------------------
	// Palette
	// ------------------------------
	localparam int PAL_DEPTH = 16;
	localparam int PAL_IDX_W = 4;
	localparam int RGB_W = 24;

	typedef logic [PAL_IDX_W-1:0] pal_idx_t;
	typedef logic [RGB_W-1:0] rgb_t;         // Red in the top byte.

	localparam pal_idx_t SLOT_BORDER = 4'd0;
	localparam pal_idx_t SLOT_GROUND = 4'd1;
	localparam pal_idx_t SLOT_BOMB = 4'd2;
	localparam pal_idx_t SLOT_WALL = 4'd3;
	localparam pal_idx_t SLOT_FLAME = 4'd4;
	localparam pal_idx_t SLOT_TREE = 4'd5;
	localparam pal_idx_t SLOT_COIN = 4'd6;
	localparam pal_idx_t SLOT_P1_BASE = 4'd8;  // Plus front, back, left, right.
	localparam pal_idx_t SLOT_P2_BASE = 4'd12;

	localparam rgb_t PAL_RESET [0:PAL_DEPTH-1] = '{
		24'h343D46, 24'h6B8E23, 24'h202020, 24'h808080,
		24'hFF6A00, 24'h2E7D32, 24'hE1D700, 24'h000000,
		24'hFFDF00, 24'hF0C000, 24'hE0A800, 24'hD09000,  // Player 1 shades.
		24'h33FFFF, 24'h22DDEE, 24'h11BBDD, 24'h0099CC   // Player 2 shades.
	};

endpackage

`default_nettype wire

// File: common/pixel_if.sv
`default_nettype none

interface pixel_if;

	logic [mapper_pkg::COORD_W-1:0] x;
	logic [mapper_pkg::COORD_W-1:0] y;
	logic play;                              // Game is in the play state.
	logic in_field;                          // Play state and left of the panel.

	// Front register side.
	modport stage
	(
		output x,
		output y,
		output play,
		output in_field
	);

	// Layer stages.
	modport layer
	(
		input x,
		input y,
		input play,
		input in_field
	);

endinterface

`default_nettype wire

// File: hw/color_mapper.sv
`default_nettype none

module color_mapper
(
	input wire clk,
	input wire rst,
	input wire [mapper_pkg::COORD_W-1:0] draw_x,
	input wire [mapper_pkg::COORD_W-1:0] draw_y,
	input wire [1:0] game_state,
	input wire [mapper_pkg::COORD_W-1:0] avatar_x_1,
	input wire [mapper_pkg::COORD_W-1:0] avatar_y_1,
	input wire [mapper_pkg::COORD_W-1:0] avatar_x_2,
	input wire [mapper_pkg::COORD_W-1:0] avatar_y_2,
	input wire [1:0] avatar_dir_1,
	input wire [1:0] avatar_dir_2,
	input wire [mapper_pkg::MAP_BITS-1:0] wall_map,
	input wire [mapper_pkg::MAP_BITS-1:0] tree_map,
	input wire [mapper_pkg::MAP_BITS-1:0] treasure_map,
	input wire [mapper_pkg::MAP_BITS-1:0] bomb_map,
	input wire [mapper_pkg::MAP_BITS-1:0] flame_map,
	input wire pal_we,
	input wire [mapper_pkg::PAL_IDX_W-1:0] pal_addr,
	input wire [mapper_pkg::RGB_W-1:0] pal_data,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	pixel_if pix ();

	logic tile_hit;
	mapper_pkg::pal_idx_t tile_slot;
	logic av_hit;
	mapper_pkg::pal_idx_t av_slot;
	mapper_pkg::pal_idx_t rd_idx;
	mapper_pkg::rgb_t rd_color;
	mapper_pkg::rgb_t rgb;

	// ------------------------------
	// Front stage
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pix.play <= 1'b0;
			pix.in_field <= 1'b0;
		end
		else
		begin
			pix.play <= (game_state == mapper_pkg::STATE_PLAY);
			pix.in_field <= (game_state == mapper_pkg::STATE_PLAY)
				&& (int'(draw_x) < mapper_pkg::FIELD_W);
		end
		pix.x <= draw_x;
		pix.y <= draw_y;
	end

	tile_layer i_tile_layer (.clk(clk), .rst(rst), .pix(pix), .wall_map(wall_map),
		.tree_map(tree_map), .treasure_map(treasure_map), .bomb_map(bomb_map),
		.flame_map(flame_map), .tile_hit(tile_hit), .tile_slot(tile_slot));

	avatar_layer i_avatar_layer (.clk(clk), .rst(rst), .pix(pix),
		.avatar_x_1(avatar_x_1), .avatar_y_1(avatar_y_1), .avatar_dir_1(avatar_dir_1),
		.avatar_x_2(avatar_x_2), .avatar_y_2(avatar_y_2), .avatar_dir_2(avatar_dir_2),
		.av_hit(av_hit), .av_slot(av_slot));

	palette_regs i_palette_regs (.clk(clk), .rst(rst), .pal_we(pal_we),
		.pal_addr(pal_addr), .pal_data(pal_data), .rd_idx(rd_idx), .rd_color(rd_color));

	pixel_compose i_pixel_compose (.clk(clk), .rst(rst), .av_hit(av_hit),
		.av_slot(av_slot), .tile_hit(tile_hit), .tile_slot(tile_slot),
		.rd_idx(rd_idx), .rd_color(rd_color), .rgb(rgb));

	assign vga_r = rgb[23:16];
	assign vga_g = rgb[15:8];
	assign vga_b = rgb[7:0];

endmodule

`default_nettype wire

// File: hw/palette_regs.sv
`default_nettype none

module palette_regs
(
	input wire clk,
	input wire rst,
	input wire pal_we,
	input wire mapper_pkg::pal_idx_t pal_addr,
	input wire mapper_pkg::rgb_t pal_data,
	input wire mapper_pkg::pal_idx_t rd_idx,
	output mapper_pkg::rgb_t rd_color
);

	mapper_pkg::rgb_t pal [0:mapper_pkg::PAL_DEPTH-1];

	// ------------------------------
	// Write port
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			pal <= mapper_pkg::PAL_RESET;        // Default game colors.
		else if (pal_we)
			pal[pal_addr] <= pal_data;
	end

	// Old contents until the edge after a write.
	assign rd_color = pal[rd_idx];

endmodule

`default_nettype wire

// File: hw/pixel_compose.sv
`default_nettype none

module pixel_compose
(
	input wire clk,
	input wire rst,
	input wire av_hit,
	input wire mapper_pkg::pal_idx_t av_slot,
	input wire tile_hit,
	input wire mapper_pkg::pal_idx_t tile_slot,
	output mapper_pkg::pal_idx_t rd_idx,
	input wire mapper_pkg::rgb_t rd_color,
	output mapper_pkg::rgb_t rgb
);

	// ------------------------------
	// Slot select
	// ------------------------------
	always_comb
	begin
		if (av_hit)
			rd_idx = av_slot;                    // Avatars cover tiles.
		else if (tile_hit)
			rd_idx = tile_slot;
		else
			rd_idx = mapper_pkg::SLOT_BORDER;
	end

	// ------------------------------
	// Output register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			rgb <= mapper_pkg::PAL_RESET[mapper_pkg::SLOT_BORDER];
		else
			rgb <= rd_color;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the color mapper testbench with Verilator, run it and scan the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_color_mapper -o tb_color_mapper -f build.f \
	&& ./obj_dir/tb_color_mapper > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
exit 0

// File: testbench/color_mapper_assertions.sv
`default_nettype none

module color_mapper_assertions
(
	input wire clk,
	input wire rst,
	input wire av_hit,
	input wire mapper_pkg::pal_idx_t rd_idx,
	input wire mapper_pkg::rgb_t rgb
);

	timeunit 1ns;
	timeprecision 100ps;

	// Output register always holds a defined color.
	rgb_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(rgb))
		else $error("rgb has unknown bits");

	// Player shades only where an avatar is drawn.
	avatar_slots: assert property (@(posedge clk) disable iff (rst)
		av_hit == (rd_idx >= mapper_pkg::SLOT_P1_BASE))
		else $error("rd_idx %h does not match av_hit %b", rd_idx, av_hit);

endmodule

bind pixel_compose color_mapper_assertions i_color_mapper_assertions
(
	.clk(clk), .rst(rst), .av_hit(av_hit),
	.rd_idx(rd_idx), .rgb(rgb)
);

`default_nettype wire

// File: testbench/tb_color_mapper.sv
`default_nettype none

module tb_color_mapper;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DELAY = 10;         // After the rising edge.
	localparam int WAIT_LIMIT = 16;
	localparam mapper_pkg::rgb_t BORDER_RGB = 24'h343D46;

	logic clk;
	logic rst;
	logic [mapper_pkg::COORD_W-1:0] draw_x;
	logic [mapper_pkg::COORD_W-1:0] draw_y;
	logic [1:0] game_state;
	logic [mapper_pkg::COORD_W-1:0] avatar_x_1;
	logic [mapper_pkg::COORD_W-1:0] avatar_y_1;
	logic [mapper_pkg::COORD_W-1:0] avatar_x_2;
	logic [mapper_pkg::COORD_W-1:0] avatar_y_2;
	logic [1:0] avatar_dir_1;
	logic [1:0] avatar_dir_2;
	logic [mapper_pkg::MAP_BITS-1:0] wall_map;
	logic [mapper_pkg::MAP_BITS-1:0] tree_map;
	logic [mapper_pkg::MAP_BITS-1:0] treasure_map;
	logic [mapper_pkg::MAP_BITS-1:0] bomb_map;
	logic [mapper_pkg::MAP_BITS-1:0] flame_map;
	logic pal_we;
	logic [mapper_pkg::PAL_IDX_W-1:0] pal_addr;
	logic [mapper_pkg::RGB_W-1:0] pal_data;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	// ------------------------------
	// Model pipe
	// ------------------------------
	logic [mapper_pkg::COORD_W-1:0] m_x;
	logic [mapper_pkg::COORD_W-1:0] m_y;
	logic m_play;
	logic m_in_field;
	mapper_pkg::pal_idx_t m_slot;
	mapper_pkg::rgb_t m_rgb;
	mapper_pkg::rgb_t m_pal [0:mapper_pkg::PAL_DEPTH-1];

	color_mapper i_color_mapper
	(
		.clk(clk), .rst(rst), .draw_x(draw_x), .draw_y(draw_y), .game_state(game_state),
		.avatar_x_1(avatar_x_1), .avatar_y_1(avatar_y_1), .avatar_x_2(avatar_x_2),
		.avatar_y_2(avatar_y_2), .avatar_dir_1(avatar_dir_1), .avatar_dir_2(avatar_dir_2),
		.wall_map(wall_map), .tree_map(tree_map), .treasure_map(treasure_map),
		.bomb_map(bomb_map), .flame_map(flame_map), .pal_we(pal_we), .pal_addr(pal_addr),
		.pal_data(pal_data), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	function automatic int clamp(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic logic [mapper_pkg::MAP_BITS-1:0] random_map(input int fill);
		logic [mapper_pkg::MAP_BITS-1:0] m;
		int i;
		for (i = 0; i < mapper_pkg::MAP_BITS; i++)
			m[i] = (rand_range(0, 99) < fill);  // Fill in percent.
		return m;
	endfunction

	function automatic mapper_pkg::pal_idx_t tile_slot(input int x, input int y);
		int idx;
		int ox;
		int oy;
		logic coin;
		idx = (y / mapper_pkg::CELL_PX) * mapper_pkg::GRID_N + x / mapper_pkg::CELL_PX;
		ox = x % mapper_pkg::CELL_PX;
		oy = y % mapper_pkg::CELL_PX;
		coin = (ox >= mapper_pkg::COIN_LO) && (ox <= mapper_pkg::COIN_HI)
			&& (oy >= mapper_pkg::COIN_LO) && (oy <= mapper_pkg::COIN_HI);
		if (bomb_map[idx])
			return mapper_pkg::SLOT_BOMB;
		if (wall_map[idx])
			return mapper_pkg::SLOT_WALL;
		if (flame_map[idx])
			return mapper_pkg::SLOT_FLAME;
		if (tree_map[idx])
			return mapper_pkg::SLOT_TREE;
		if (treasure_map[idx] && coin)
			return mapper_pkg::SLOT_COIN;
		return mapper_pkg::SLOT_GROUND;
	endfunction

	function automatic logic in_hitbox(input int px, input int py, input int ax, input int ay);
		return (px >= ax - mapper_pkg::AV_HALF_W) && (px < ax + mapper_pkg::AV_HALF_W)
			&& (py >= ay - mapper_pkg::AV_UP) && (py < ay + mapper_pkg::AV_DOWN);
	endfunction

	// Slot for the pixel now held in the model front stage.
	function automatic mapper_pkg::pal_idx_t expected_slot();
		if (m_play && in_hitbox(int'(m_x), int'(m_y), int'(avatar_x_1), int'(avatar_y_1)))
			return mapper_pkg::SLOT_P1_BASE + mapper_pkg::pal_idx_t'(avatar_dir_1);
		if (m_play && in_hitbox(int'(m_x), int'(m_y), int'(avatar_x_2), int'(avatar_y_2)))
			return mapper_pkg::SLOT_P2_BASE + mapper_pkg::pal_idx_t'(avatar_dir_2);
		if (m_in_field)
			return tile_slot(int'(m_x), int'(m_y));
		return mapper_pkg::SLOT_BORDER;
	endfunction

	task automatic update_model();
		int i;
		if (rst)
		begin
			for (i = 0; i < mapper_pkg::PAL_DEPTH; i++)
				m_pal[i] = mapper_pkg::PAL_RESET[i];
			m_play = 1'b0;
			m_in_field = 1'b0;
			m_slot = mapper_pkg::SLOT_BORDER;
			m_rgb = mapper_pkg::PAL_RESET[mapper_pkg::SLOT_BORDER];
		end
		else
		begin
			m_rgb = m_pal[m_slot];               // Palette before this edge.
			m_slot = expected_slot();
			m_play = (game_state == mapper_pkg::STATE_PLAY);
			m_in_field = m_play && (int'(draw_x) < mapper_pkg::FIELD_W);
			if (pal_we)
				m_pal[pal_addr] = pal_data;
		end
		m_x = draw_x;
		m_y = draw_y;
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			report_failure("output color does not match the model");
		end
	endtask

	task automatic check_output();
		check_value("vga_r", vga_r, m_rgb[23:16]);
		check_value("vga_g", vga_g, m_rgb[15:8]);
		check_value("vga_b", vga_b, m_rgb[7:0]);
	endtask

	task automatic step_clock();
		@(posedge clk);
		update_model();
		#DRIVE_DELAY;
	endtask

	task automatic next_cycle();
		step_clock();
		check_output();
	endtask

	task automatic wait_for_border();
		int n;
		n = 0;
		while ({vga_r, vga_g, vga_b} !== BORDER_RGB)
		begin
			if (n == WAIT_LIMIT)
				report_failure("timed out waiting for the border color after reset");
			step_clock();
			n++;
		end
	endtask

	task automatic drive_pixel(input int x, input int y, input logic [1:0] state);
		draw_x = 10'(x);
		draw_y = 10'(y);
		game_state = state;
	endtask

	// Box edges lie inside these offsets.
	task automatic drive_near(input int ax, input int ay);
		drive_pixel(clamp(ax + rand_range(-25, 24), 0, 639),
			clamp(ay + rand_range(-45, 24), 0, 479), mapper_pkg::STATE_PLAY);
	endtask

	task automatic place_avatars(input int x1, input int y1, input int x2, input int y2);
		avatar_x_1 = 10'(x1);
		avatar_y_1 = 10'(y1);
		avatar_x_2 = 10'(x2);
		avatar_y_2 = 10'(y2);
	endtask

	task automatic randomize_maps(input int fill);
		wall_map = random_map(fill);
		tree_map = random_map(fill);
		treasure_map = random_map(fill);
		bomb_map = random_map(fill);
		flame_map = random_map(fill);
	endtask

	initial
	begin
		int i;
		int ax;
		int ay;
		logic [1:0] st;
		void'($urandom(32'h7a0d));
		rst = 1'b1;
		drive_pixel(0, 0, 2'b00);
		place_avatars(0, 0, 0, 0);
		avatar_dir_1 = 2'b00;
		avatar_dir_2 = 2'b00;
		randomize_maps(0);
		pal_we = 1'b0;
		pal_addr = '0;
		pal_data = '0;
		repeat (3) step_clock();
		rst = 1'b0;
		wait_for_border();

		// Reset palette over all kinds of pixels.
		randomize_maps(25);
		for (i = 0; i < 600; i++)
		begin
			if (i % 50 == 0)
				place_avatars(rand_range(0, 639), rand_range(0, 479),
					rand_range(0, 639), rand_range(0, 479));
			drive_pixel(rand_range(0, 639), rand_range(0, 479), 2'(rand_range(0, 3)));
			next_cycle();
		end

		// Tile layers with both avatars parked off screen.
		place_avatars(1000, 1000, 1000, 1000);
		for (i = 0; i < 3000; i++)
		begin
			if (i % 250 == 0)
				randomize_maps(rand_range(10, 50));
			drive_pixel(rand_range(0, 479), rand_range(0, 479), mapper_pkg::STATE_PLAY);
			next_cycle();
		end

		// ------------------------------
		// Avatar boxes
		// ------------------------------
		randomize_maps(25);
		for (i = 0; i < 3000; i++)
		begin
			if (i % 8 == 0)
			begin
				ax = rand_range(30, 450);
				ay = rand_range(50, 420);
				if (rand_range(0, 1) == 1)
					place_avatars(ax, ay, ax + rand_range(-30, 30), ay + rand_range(-30, 30));
				else
					place_avatars(ax, ay, rand_range(30, 450), rand_range(50, 420));
			end
			avatar_dir_1 = 2'($urandom);
			avatar_dir_2 = 2'($urandom);
			if (rand_range(0, 1) == 1)
				drive_near(int'(avatar_x_1), int'(avatar_y_1));
			else
				drive_near(int'(avatar_x_2), int'(avatar_y_2));
			next_cycle();
		end

		// Border outside the play state and right of the field.
		place_avatars(0, 0, 0, 0);
		for (i = 0; i < 1500; i++)
		begin
			st = 2'(rand_range(0, 2));
			if (st == mapper_pkg::STATE_PLAY)
				st = 2'b11;
			if (rand_range(0, 1) == 1)
				drive_pixel(rand_range(0, 639), rand_range(0, 479), st);
			else
				drive_pixel(rand_range(480, 1023), rand_range(0, 479), mapper_pkg::STATE_PLAY);
			next_cycle();
		end

		// ------------------------------
		// Palette writes under traffic
		// ------------------------------
		for (i = 0; i < 3000; i++)
		begin
			if (i % 16 == 0)
			begin
				randomize_maps(25);
				place_avatars(rand_range(30, 450), rand_range(50, 420),
					rand_range(30, 450), rand_range(50, 420));
			end
			avatar_dir_1 = 2'($urandom);
			avatar_dir_2 = 2'($urandom);
			pal_we = (rand_range(0, 3) == 0);
			pal_addr = 4'($urandom);
			pal_data = 24'($urandom);
			if (rand_range(0, 1) == 1)
				drive_near(int'(avatar_x_1), int'(avatar_y_1));
			else
				drive_pixel(rand_range(0, 639), rand_range(0, 479),
					(rand_range(0, 4) == 0) ? 2'b10 : mapper_pkg::STATE_PLAY);
			next_cycle();
		end
		pal_we = 1'b0;
		repeat (3) next_cycle();          // Drain the pipe.

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: tile_layer/tile_layer.sv
`default_nettype none

module tile_layer
(
	input wire clk,
	input wire rst,
	pixel_if.layer pix,
	input wire [mapper_pkg::MAP_BITS-1:0] wall_map,
	input wire [mapper_pkg::MAP_BITS-1:0] tree_map,
	input wire [mapper_pkg::MAP_BITS-1:0] treasure_map,
	input wire [mapper_pkg::MAP_BITS-1:0] bomb_map,
	input wire [mapper_pkg::MAP_BITS-1:0] flame_map,
	output logic tile_hit,
	output mapper_pkg::pal_idx_t tile_slot
);

	int cell_x;
	int cell_y;
	int off_x;
	int off_y;
	int cell_idx;
	logic coin_box;
	mapper_pkg::pal_idx_t slot_next;

	// Rows past the grid read as empty.
	function automatic logic occupied
	(
		input logic [mapper_pkg::MAP_BITS-1:0] map,
		input int idx
	);
		return (idx < mapper_pkg::MAP_BITS) ? map[idx] : 1'b0;
	endfunction

	// ------------------------------
	// Cell and offset
	// ------------------------------
	always_comb
	begin
		cell_x = int'(pix.x) / mapper_pkg::CELL_PX;
		cell_y = int'(pix.y) / mapper_pkg::CELL_PX;
		off_x = int'(pix.x) - cell_x * mapper_pkg::CELL_PX;
		off_y = int'(pix.y) - cell_y * mapper_pkg::CELL_PX;
		cell_idx = cell_y * mapper_pkg::GRID_N + cell_x;
	end

	assign coin_box = (off_x >= mapper_pkg::COIN_LO) && (off_x <= mapper_pkg::COIN_HI)
		&& (off_y >= mapper_pkg::COIN_LO) && (off_y <= mapper_pkg::COIN_HI);

	// ------------------------------
	// Layer priority
	// ------------------------------
	always_comb
	begin
		if (occupied(bomb_map, cell_idx))
			slot_next = mapper_pkg::SLOT_BOMB;
		else if (occupied(wall_map, cell_idx))
			slot_next = mapper_pkg::SLOT_WALL;
		else if (occupied(flame_map, cell_idx))
			slot_next = mapper_pkg::SLOT_FLAME;
		else if (occupied(tree_map, cell_idx))
			slot_next = mapper_pkg::SLOT_TREE;
		else if (coin_box && occupied(treasure_map, cell_idx))
			slot_next = mapper_pkg::SLOT_COIN;
		else
			slot_next = mapper_pkg::SLOT_GROUND;  // Bare floor.
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			tile_hit <= 1'b0;
		else
			tile_hit <= pix.in_field;
		tile_slot <= slot_next;
	end

endmodule

`default_nettype wire
